/* rtl/gb_mem_macros.svh */
`ifndef GB_MEM_MACROS_SVH
`define GB_MEM_MACROS_SVH

// Memory map
`define GB_ROM_END    16'h7FFF
`define GB_WRAM_START 16'hC000
`define GB_ECHO_END   16'hFDFF
`define GB_OAM_START  16'hFE00
`define GB_OAM_END    16'hFE9F
`define GB_DMA_REG    16'hFF46
`define GB_HRAM_START 16'hFF80
`define GB_HRAM_END   16'hFFFE

// Memory index widths
`define GB_WRAM_BITS 13
`define GB_HRAM_BITS 7
`define GB_OAM_BITS  8
`define GB_ROM_BITS  6

// Bytes moved by one OAM DMA
`define GB_OAM_LEN 160

`endif

/* rtl/gb_mem_pkg.sv */
package gb_mem_pkg;

  // High and low byte of a bus address
  typedef struct packed {
    logic [7:0] page;
    logic [7:0] offset;
  } bus_addr_split_t;

  // Same address word, as a flat value or as page and offset
  typedef union packed {
    logic [15:0]     raw;
    bus_addr_split_t split;
  } bus_addr_u;

  // CPU side of the bus
  typedef struct packed {
    bus_addr_u  addr;
    logic [7:0] wdata;
    logic       read_en;
    logic       write_en;
  } cpu_req_t;

  // OAM DMA side of the bus
  typedef struct packed {
    bus_addr_u  addr;
    logic [7:0] wdata;
    logic       read_en;
    logic       write_en;
    logic       active;
  } dma_req_t;

  // Per-target request from the MMU, index is local to the target
  typedef struct packed {
    logic [15:0] index;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } mem_port_t;

endpackage

/* rtl/byte_ram.sv */
module byte_ram #(
  parameter int INDEX_BITS = 8
) (
  input  logic                  clk,
  input  gb_mem_pkg::mem_port_t port,
  output logic [7:0]            rdata
);

  logic [7:0]            mem [2**INDEX_BITS];
  logic [INDEX_BITS-1:0] idx;

  assign idx = port.index[INDEX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (port.write_en) mem[idx] <= port.wdata;
    // Registered read, valid next cycle
    if (port.read_en) rdata <= mem[idx];
  end

endmodule

/* rtl/cart_rom.sv */
module cart_rom #(
  parameter int INDEX_BITS = 6
) (
  input  logic                  clk,
  input  gb_mem_pkg::mem_port_t port,
  output logic [7:0]            rdata
);

  logic [7:0]            mem [2**INDEX_BITS];
  logic [INDEX_BITS-1:0] idx;

  initial begin
    $readmemh("rom.hex", mem);
  end

  // Upper address bits drop out, so the image mirrors
  assign idx = port.index[INDEX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (port.read_en) rdata <= mem[idx];
  end

endmodule

/* rtl/mmu.sv */
`include "gb_mem_macros.svh"

module mmu (
  input  logic                  clk,
  input  logic                  rst_n,
  input  gb_mem_pkg::cpu_req_t  cpu_req,
  output logic [7:0]            cpu_rdata,
  input  gb_mem_pkg::dma_req_t  dma_req,
  output logic [7:0]            dma_rdata,
  output gb_mem_pkg::mem_port_t rom_port,
  output gb_mem_pkg::mem_port_t wram_port,
  output gb_mem_pkg::mem_port_t hram_port,
  output gb_mem_pkg::mem_port_t oam_port,
  output gb_mem_pkg::mem_port_t reg_port,
  input  logic [7:0]            rom_rdata,
  input  logic [7:0]            wram_rdata,
  input  logic [7:0]            hram_rdata,
  input  logic [7:0]            oam_rdata,
  input  logic [7:0]            reg_rdata
);

  // Read source codes
  localparam logic [2:0] src_none = 3'd0;
  localparam logic [2:0] src_rom  = 3'd1;
  localparam logic [2:0] src_wram = 3'd2;
  localparam logic [2:0] src_oam  = 3'd3;
  localparam logic [2:0] src_hram = 3'd4;
  localparam logic [2:0] src_reg  = 3'd5;

  localparam logic [15:0] dma_reg = `GB_DMA_REG;

  gb_mem_pkg::bus_addr_u eff_addr;
  logic                  active;
  logic                  rom_hit;
  logic                  wram_hit;
  logic                  oam_hit;
  logic                  hram_hit;
  logic                  reg_hit;
  logic                  path_rd;
  logic                  path_wr;
  logic [2:0]            cpu_src_d;
  logic [2:0]            cpu_src_q;
  logic [2:0]            dma_src_d;
  logic [2:0]            dma_src_q;
  logic [7:0]            dma_off_q;

  function automatic logic [7:0] pick_byte(
    input logic [2:0] src,
    input logic [7:0] rom_b,
    input logic [7:0] wram_b,
    input logic [7:0] oam_b,
    input logic [7:0] hram_b,
    input logic [7:0] reg_b
  );
    logic [7:0] b;
    case (src)
      src_rom:  b = rom_b;
      src_wram: b = wram_b;
      src_oam:  b = oam_b;
      src_hram: b = hram_b;
      src_reg:  b = reg_b;
      default:  b = 8'hFF;
    endcase
    return b;
  endfunction

  // DMA owns the ROM, work RAM and OAM paths while it runs
  assign active   = dma_req.active;
  assign eff_addr = active ? dma_req.addr : cpu_req.addr;

  assign rom_hit  = eff_addr.raw <= `GB_ROM_END;
  assign wram_hit = eff_addr.raw inside {[`GB_WRAM_START : `GB_ECHO_END]};
  assign oam_hit  = eff_addr.raw inside {[`GB_OAM_START : `GB_OAM_END]};
  assign hram_hit = cpu_req.addr.raw inside {[`GB_HRAM_START : `GB_HRAM_END]};
  assign reg_hit  = (cpu_req.addr.split.page == dma_reg[15:8]) &&
                    (cpu_req.addr.split.offset == dma_reg[7:0]);

  // The DMA engine only reads over the shared path
  assign path_rd = active ? dma_req.read_en : cpu_req.read_en;
  assign path_wr = cpu_req.write_en && !active;

  always_comb begin
    rom_port.index     = eff_addr.raw;
    rom_port.wdata     = cpu_req.wdata;
    rom_port.read_en   = path_rd && rom_hit;
    rom_port.write_en  = path_wr && rom_hit;

    // Echo lands on the same low 13 bits
    wram_port.index    = eff_addr.raw;
    wram_port.wdata    = cpu_req.wdata;
    wram_port.read_en  = path_rd && wram_hit;
    wram_port.write_en = path_wr && wram_hit;

    hram_port.index    = cpu_req.addr.raw;
    hram_port.wdata    = cpu_req.wdata;
    hram_port.read_en  = cpu_req.read_en && hram_hit;
    hram_port.write_en = cpu_req.write_en && hram_hit;

    reg_port.index     = cpu_req.addr.raw;
    reg_port.wdata     = cpu_req.wdata;
    reg_port.read_en   = cpu_req.read_en && reg_hit;
    reg_port.write_en  = cpu_req.write_en && reg_hit;
  end

  // Each DMA write goes to the offset of the read that fetched the byte
  always_comb begin
    if (active) begin
      oam_port.index    = {8'h00, dma_off_q};
      oam_port.wdata    = dma_req.wdata;
      oam_port.read_en  = 1'b0;
      oam_port.write_en = dma_req.write_en;
    end else begin
      oam_port.index    = {8'h00, eff_addr.split.offset};
      oam_port.wdata    = cpu_req.wdata;
      oam_port.read_en  = cpu_req.read_en && oam_hit;
      oam_port.write_en = cpu_req.write_en && oam_hit;
    end
  end

  always_comb begin
    cpu_src_d = src_none;
    if (cpu_req.read_en) begin
      if (reg_hit) cpu_src_d = src_reg;
      else if (hram_hit) cpu_src_d = src_hram;
      else if (!active && rom_hit) cpu_src_d = src_rom;
      else if (!active && wram_hit) cpu_src_d = src_wram;
      else if (!active && oam_hit) cpu_src_d = src_oam;
    end
  end

  always_comb begin
    dma_src_d = src_none;
    if (active && dma_req.read_en) begin
      if (rom_hit) dma_src_d = src_rom;
      else if (wram_hit) dma_src_d = src_wram;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cpu_src_q <= src_none;
      dma_src_q <= src_none;
    end else begin
      cpu_src_q <= cpu_src_d;
      dma_src_q <= dma_src_d;
    end
  end

  always_ff @(posedge clk) begin
    if (dma_req.read_en) dma_off_q <= dma_req.addr.split.offset;
  end

  // Memories answer one cycle after the strobe
  assign cpu_rdata = pick_byte(cpu_src_q, rom_rdata, wram_rdata, oam_rdata,
                               hram_rdata, reg_rdata);
  assign dma_rdata = pick_byte(dma_src_q, rom_rdata, wram_rdata, oam_rdata,
                               hram_rdata, reg_rdata);

endmodule

/* rtl/oam_dma.sv */
`include "gb_mem_macros.svh"

module oam_dma (
  input  logic                  clk,
  input  logic                  rst_n,
  input  gb_mem_pkg::mem_port_t reg_port,
  output logic [7:0]            reg_rdata,
  output gb_mem_pkg::dma_req_t  dma_req,
  input  logic [7:0]            dma_rdata
);

  localparam logic [7:0]  last_off = 8'(`GB_OAM_LEN - 1);
  localparam logic [15:0] oam_base = `GB_OAM_START;

  logic [7:0]            page_q;
  logic                  active_q;
  logic [7:0]            rd_off_q;
  logic                  wr_valid_q;
  logic [7:0]            wr_off_q;
  logic                  reading;
  logic                  start;
  gb_mem_pkg::bus_addr_u src_addr;
  gb_mem_pkg::bus_addr_u oam_addr;

  // A new page is only taken while idle
  assign start   = reg_port.write_en && !active_q;
  assign reading = active_q && (rd_off_q <= last_off);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      page_q     <= 8'h00;
      active_q   <= 1'b0;
      rd_off_q   <= 8'h00;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= reading;
      if (start) begin
        page_q   <= reg_port.wdata;
        active_q <= 1'b1;
        rd_off_q <= 8'h00;
      end else begin
        if (reading) rd_off_q <= rd_off_q + 8'd1;
        // Done once the last byte is written
        if (wr_valid_q && (wr_off_q == last_off)) active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_off_q <= rd_off_q;
    if (reg_port.read_en) reg_rdata <= page_q;
  end

  always_comb begin
    src_addr.split.page   = page_q;
    src_addr.split.offset = rd_off_q;
    oam_addr.split.page   = oam_base[15:8];
    oam_addr.split.offset = wr_off_q;
  end

  // Tail cycle has only the OAM write left
  always_comb begin
    dma_req.addr     = reading ? src_addr : oam_addr;
    dma_req.wdata    = dma_rdata;
    dma_req.read_en  = reading;
    dma_req.write_en = wr_valid_q;
    dma_req.active   = active_q;
  end

endmodule

/* rtl/mem_subsys.sv */
`include "gb_mem_macros.svh"

module mem_subsys (
  input  logic                 clk,
  input  logic                 rst_n,
  input  gb_mem_pkg::cpu_req_t cpu_req,
  output logic [7:0]           cpu_rdata,
  output logic                 dma_active
);

  gb_mem_pkg::dma_req_t  dma_req;
  gb_mem_pkg::mem_port_t rom_port;
  gb_mem_pkg::mem_port_t wram_port;
  gb_mem_pkg::mem_port_t hram_port;
  gb_mem_pkg::mem_port_t oam_port;
  gb_mem_pkg::mem_port_t reg_port;
  logic [7:0]            dma_rdata;
  logic [7:0]            rom_rdata;
  logic [7:0]            wram_rdata;
  logic [7:0]            hram_rdata;
  logic [7:0]            oam_rdata;
  logic [7:0]            reg_rdata;

  assign dma_active = dma_req.active;

  mmu u_mmu (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_req    (cpu_req),
    .cpu_rdata  (cpu_rdata),
    .dma_req    (dma_req),
    .dma_rdata  (dma_rdata),
    .rom_port   (rom_port),
    .wram_port  (wram_port),
    .hram_port  (hram_port),
    .oam_port   (oam_port),
    .reg_port   (reg_port),
    .rom_rdata  (rom_rdata),
    .wram_rdata (wram_rdata),
    .hram_rdata (hram_rdata),
    .oam_rdata  (oam_rdata),
    .reg_rdata  (reg_rdata)
  );

  oam_dma u_oam_dma (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_port  (reg_port),
    .reg_rdata (reg_rdata),
    .dma_req   (dma_req),
    .dma_rdata (dma_rdata)
  );

  cart_rom #(.INDEX_BITS(`GB_ROM_BITS)) u_rom (
    .clk   (clk),
    .port  (rom_port),
    .rdata (rom_rdata)
  );

  byte_ram #(.INDEX_BITS(`GB_WRAM_BITS)) u_wram (
    .clk   (clk),
    .port  (wram_port),
    .rdata (wram_rdata)
  );

  byte_ram #(.INDEX_BITS(`GB_HRAM_BITS)) u_hram (
    .clk   (clk),
    .port  (hram_port),
    .rdata (hram_rdata)
  );

  byte_ram #(.INDEX_BITS(`GB_OAM_BITS)) u_oam (
    .clk   (clk),
    .port  (oam_port),
    .rdata (oam_rdata)
  );

endmodule

/* sim/tb_clock.sv */
module tb_clock (
  output logic clk
);

  localparam int half_period = 10;

  initial clk = 1'b0;

  always #half_period clk = ~clk;

endmodule

/* sim/mmu_checker.sv */
`include "gb_mem_macros.svh"

module mmu_checker (
  input logic                  clk,
  input logic                  rst_n,
  input gb_mem_pkg::cpu_req_t  cpu_req,
  input logic [7:0]            cpu_rdata,
  input gb_mem_pkg::dma_req_t  dma_req,
  input gb_mem_pkg::mem_port_t rom_port,
  input gb_mem_pkg::mem_port_t wram_port,
  input gb_mem_pkg::mem_port_t hram_port,
  input gb_mem_pkg::mem_port_t oam_port,
  input gb_mem_pkg::mem_port_t reg_port
);

  logic [4:0] strobes;
  logic       cpu_leak;
  logic       unmapped;
  int         fail_count = 0;

  assign strobes = {rom_port.read_en || rom_port.write_en,
                    wram_port.read_en || wram_port.write_en,
                    hram_port.read_en || hram_port.write_en,
                    oam_port.read_en || oam_port.write_en,
                    reg_port.read_en || reg_port.write_en};

  // Any use of the DMA-owned paths that the DMA engine did not ask for
  assign cpu_leak = rom_port.write_en || wram_port.write_en || oam_port.read_en ||
                    (oam_port.write_en != dma_req.write_en) ||
                    ((rom_port.read_en || wram_port.read_en) && !dma_req.read_en);

  assign unmapped = !((cpu_req.addr.raw <= `GB_ROM_END) ||
                      (cpu_req.addr.raw inside {[`GB_WRAM_START : `GB_ECHO_END]}) ||
                      (cpu_req.addr.raw inside {[`GB_OAM_START : `GB_OAM_END]}) ||
                      (cpu_req.addr.raw inside {[`GB_HRAM_START : `GB_HRAM_END]}) ||
                      (cpu_req.addr.raw == `GB_DMA_REG));

  one_port: assert property (@(posedge clk) disable iff (!rst_n)
    !dma_req.active |-> $onehot0(strobes))
    else begin fail_count++; $error("more than one memory port strobed"); end

  dma_owns_paths: assert property (@(posedge clk) disable iff (!rst_n)
    dma_req.active |-> !cpu_leak)
    else begin fail_count++; $error("CPU strobe on a DMA-owned path"); end

  unmapped_reads_ff: assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_req.read_en && unmapped) |=> (cpu_rdata == 8'hFF))
    else begin fail_count++; $error("unmapped read did not return FF"); end

endmodule

/* sim/mem_subsys_tb.sv */
module mem_subsys_tb;

  // Tests need about 6000 cycles so this leaves wide margin
  localparam int timeout_cycles = 20000;

  logic                 clk;
  logic                 rst_n;
  gb_mem_pkg::cpu_req_t cpu_req;
  logic [7:0]           cpu_rdata;
  logic                 dma_active;
  logic [7:0]           rom_model [64];
  logic [7:0]           wram_model [8192];
  logic                 wram_valid [8192];
  logic [7:0]           hram_model [128];
  logic                 hram_valid [128];
  logic [7:0]           oam_model [160];
  logic [7:0]           dma_page;
  logic [15:0]          dropped_q [$];
  int                   cycles = 0;

  tb_clock u_clock (.clk(clk));

  mem_subsys UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_req    (cpu_req),
    .cpu_rdata  (cpu_rdata),
    .dma_active (dma_active)
  );

  bind mmu mmu_checker u_mmu_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .cpu_rdata (cpu_rdata),
    .dma_req   (dma_req),
    .rom_port  (rom_port),
    .wram_port (wram_port),
    .hram_port (hram_port),
    .oam_port  (oam_port),
    .reg_port  (reg_port)
  );

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (UUT.u_mmu.u_mmu_checker.fail_count != 0) begin
      $display("an MMU assertion failed");
      $display("** FAIL **");
      $fatal(1, "assertion failure");
    end
    if (cycles >= timeout_cycles) begin
      $display("simulation timed out");
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %02h, actual %02h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_active(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected dma_active %0b, actual %0b", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "dma_active mismatch");
    end
  endtask

  // Each access takes one cycle and returns at the next drive point
  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    cpu_req.addr.raw = addr;
    cpu_req.wdata    = data;
    cpu_req.read_en  = 1'b0;
    cpu_req.write_en = 1'b1;
    @(posedge clk);
    #2;
    cpu_req.write_en = 1'b0;
  endtask

  task automatic cpu_read(input string name, input logic [15:0] addr, input logic [7:0] exp);
    cpu_req.addr.raw = addr;
    cpu_req.read_en  = 1'b1;
    cpu_req.write_en = 1'b0;
    @(posedge clk);
    #2;
    cpu_req.read_en = 1'b0;
    check_byte(name, exp, cpu_rdata);
  endtask

  // Work RAM index reached through C000 or its echo at E000
  function automatic logic [15:0] wram_alias(input logic [12:0] idx);
    logic [15:0] addr;
    addr = 16'hE000 | {3'b000, idx};
    if (($urandom % 2 == 0) || (addr > 16'hFDFF)) addr = 16'hC000 | {3'b000, idx};
    return addr;
  endfunction

  function automatic logic [15:0] unmapped_addr();
    logic [15:0] addr;
    case ($urandom % 3)
      0: addr = 16'h8000 + 16'($urandom % 16384);
      1: addr = 16'hFEA0 + 16'($urandom % 96);
      default: addr = 16'hFF00 + 16'($urandom % 128);
    endcase
    if (addr == 16'hFF46) addr = 16'hFF47;
    return addr;
  endfunction

  function automatic logic [15:0] blocked_addr();
    case ($urandom % 3)
      0: return 16'($urandom % 32768);
      1: return wram_alias(13'($urandom));
      default: return 16'hFE00 + 16'($urandom % 160);
    endcase
  endfunction

  task automatic wram_op(input string name);
    logic [12:0] idx;
    logic [7:0]  data;
    idx  = 13'($urandom) & 13'h1F0F;
    data = 8'($urandom);
    if (wram_valid[idx] && ($urandom % 2 == 0)) begin
      cpu_read(name, wram_alias(idx), wram_model[idx]);
    end else begin
      cpu_write(wram_alias(idx), data);
      wram_model[idx] = data;
      wram_valid[idx] = 1'b1;
    end
  endtask

  // Index 7F is FFFF, which is not high RAM
  task automatic hram_op(input string name);
    logic [6:0] idx;
    logic [7:0] data;
    idx  = 7'($urandom);
    data = 8'($urandom);
    if (idx == 7'h7F) begin
      if ($urandom % 2 == 0) cpu_read(name, 16'hFFFF, 8'hFF);
      else cpu_write(16'hFFFF, data);
    end else if (hram_valid[idx] && ($urandom % 2 == 0)) begin
      cpu_read(name, {9'h1FF, idx}, hram_model[idx]);
    end else begin
      cpu_write({9'h1FF, idx}, data);
      hram_model[idx] = data;
      hram_valid[idx] = 1'b1;
    end
  endtask

  task automatic busy_op();
    logic [15:0] addr;
    logic [12:0] widx;
    widx = 13'($urandom) & 13'h1F0F;
    case ($urandom % 6)
      0, 1: hram_op("dma_run");
      2: cpu_read("dma_run", 16'hFF46, dma_page);
      3: cpu_write(16'hFF46, 8'($urandom));
      4: cpu_read("dma_run", blocked_addr(), 8'hFF);
      default: begin
        addr = wram_alias(widx);
        if (wram_valid[widx]) dropped_q.push_back(addr);
        cpu_write(addr, 8'($urandom));
      end
    endcase
  endtask

  task automatic run_dma();
    logic [7:0]  page;
    logic [7:0]  off;
    logic [12:0] idx;
    logic [7:0]  data;
    page = ($urandom % 2 == 0) ? 8'($urandom % 128) : 8'(32'hC0 + $urandom % 32);
    for (int i = 0; i < 160; i++) begin
      off = 8'(i);
      idx = {page[4:0], off};
      // Work RAM source bytes get known values first
      if (page >= 8'hC0) begin
        data = 8'($urandom);
        cpu_write({page, off}, data);
        wram_model[idx] = data;
        wram_valid[idx] = 1'b1;
      end
      oam_model[off] = (page >= 8'hC0) ? wram_model[idx] : rom_model[off[5:0]];
    end
    dropped_q.delete();
    cpu_write(16'hFF46, page);
    dma_page = page;
    for (int i = 0; i < 161; i++) begin
      check_active("dma_run", 1'b1, dma_active);
      busy_op();
    end
    check_active("dma_run", 1'b0, dma_active);
    for (int i = 0; i < 160; i++) begin
      off = 8'(i);
      cpu_read("oam_after_dma", {8'hFE, off}, oam_model[off]);
    end
    cpu_read("oam_after_dma", 16'hFF46, dma_page);
    foreach (dropped_q[i]) cpu_read("dma_run", dropped_q[i], wram_model[dropped_q[i][12:0]]);
  endtask

  initial begin
    logic [15:0] addr;
    void'($urandom(10));
    rst_n   = 1'b0;
    cpu_req = '0;
    $readmemh("rom.hex", rom_model);
    for (int i = 0; i < 8192; i++) wram_valid[13'(i)] = 1'b0;
    for (int i = 0; i < 128; i++) hram_valid[7'(i)] = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_active("reset", 1'b0, dma_active);

    repeat (1500) wram_op("wram_echo");

    repeat (800) begin
      addr = 16'($urandom % 32768);
      if ($urandom % 4 == 0) cpu_write(addr, 8'($urandom));
      else cpu_read("rom", addr, rom_model[addr[5:0]]);
    end

    repeat (600) begin
      addr = unmapped_addr();
      if ($urandom % 2 == 0) cpu_write(addr, 8'($urandom));
      else cpu_read("unmapped", addr, 8'hFF);
    end

    // Work RAM contents survive the unmapped writes
    for (int i = 0; i < 8192; i++) begin
      if (wram_valid[i]) cpu_read("unmapped", wram_alias(13'(i)), wram_model[i]);
    end

    repeat (4) run_dma();

    repeat (800) hram_op("hram");

    if (UUT.u_mmu.u_mmu_checker.fail_count != 0) begin
      $display("an MMU assertion failed");
      $display("** FAIL **");
      $fatal(1, "assertion failure");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* rom.hex */
// One byte per line, cartridge offsets 00 to 3F
5A
7F
A4
C9
EE
13
38
5D
82
A7
CC
F1
16
3B
60
85
AA
CF
F4
19
3E
63
88
AD
D2
F7
1C
41
66
8B
B0
D5
FA
1F
44
69
8E
B3
D8
FD
22
47
6C
91
B6
DB
00
25
4A
6F
94
B9
DE
03
28
4D
72
97
BC
E1
06
2B
50
75

/* compile.f */
+incdir+rtl
rtl/gb_mem_pkg.sv
rtl/byte_ram.sv
rtl/cart_rom.sv
rtl/mmu.sv
rtl/oam_dma.sv
rtl/mem_subsys.sv
sim/tb_clock.sv
sim/mmu_checker.sv
sim/mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module mem_subsys_tb -f compile.f -o mem_sim || exit 1
out=$(./obj_dir/mem_sim)
echo "$out"
echo "$out" | grep -qF "** PASS **" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
